// ==== fetchExec.f ====
+incdir+tests
source/fetchExecPkg.sv
source/busCycleFsm.sv
source/prefetchQueue.sv
source/instructionDecoder.sv
source/fetchExecTop.sv
tests/fetchExecTb.sv

// ==== source/busCycleFsm.sv ====
`timescale 1ns/1ps

module busCycleFsm (
   input  logic                      CLOCK,
   input  logic                      RESET,
   input  logic                      readyN,
   input  logic                      hold,
   input  fetchExecPkg::dataWord_t   dataIn,
   input  fetchExecPkg::busRequest_t codeRequest,
   input  fetchExecPkg::busRequest_t dataRequest,
   output logic                      codeDone,
   output logic                      dataDone,
   output fetchExecPkg::dataWord_t   readData,
   output fetchExecPkg::dwordAddr_t  address,
   output fetchExecPkg::byteEnable_t byteEnableN,
   output logic                      writeReadN,
   output logic                      dataCodeN,
   output logic                      memIoN,
   output logic                      adsN,
   output fetchExecPkg::dataWord_t   dataOut
);

   fetchExecPkg::busState_t    state;
   fetchExecPkg::busRequest_t  winner;
   logic                       grantData;
   logic                       startCycle;

   // Active-low lane enables from width and low address bits
   function automatic fetchExecPkg::byteEnable_t enableFor(
      fetchExecPkg::accessWidth_t width,
      logic [1:0]                 offset
   );
      fetchExecPkg::byteEnable_t lanes;
      if (width == fetchExecPkg::widthByte)
      begin
         lanes = ~(4'b0001 << offset);
      end
      else
      begin
         case (offset)
            2'd0:    lanes = 4'b0000;
            2'd1:    lanes = 4'b0001;
            2'd2:    lanes = 4'b0011;
            default: lanes = 4'b0111;
         endcase
      end
      return lanes;
   endfunction

   // Byte writes go out on the lane picked by the address
   function automatic fetchExecPkg::dataWord_t laneData(fetchExecPkg::busRequest_t request);
      fetchExecPkg::dataWord_t word;
      if (request.width == fetchExecPkg::widthByte)
         word = fetchExecPkg::dataWord_t'(request.data[7:0]) << (8 * request.addr[1:0]);
      else
         word = request.data;
      return word;
   endfunction

   // Data cycles win over code fetches
   assign winner = dataRequest.pending ? dataRequest : codeRequest;

   assign startCycle = winner.pending && !hold &&
                       (state == fetchExecPkg::stateTi || state == fetchExecPkg::stateTh);

   assign codeDone = (state == fetchExecPkg::stateT2) && !readyN && !grantData;
   assign dataDone = (state == fetchExecPkg::stateT2) && !readyN && grantData;
   assign readData = dataIn;

   always_ff @(posedge CLOCK or posedge RESET)
   begin
      if (RESET)
      begin
         state       <= fetchExecPkg::stateTi;
         adsN        <= 1'b1;
         grantData   <= 1'b0;
         address     <= '0;
         byteEnableN <= '1;
         writeReadN  <= 1'b0;
         dataCodeN   <= 1'b1;
         memIoN      <= 1'b0;
      end
      else
      begin
         case (state)
            fetchExecPkg::stateTi:
               if (hold)
                  state <= fetchExecPkg::stateTh;
               else if (winner.pending)
                  state <= fetchExecPkg::stateT1;
            fetchExecPkg::stateTh:
               if (!hold)
                  state <= winner.pending ? fetchExecPkg::stateT1 : fetchExecPkg::stateTi;
            fetchExecPkg::stateT1:
               state <= fetchExecPkg::stateT2;
            fetchExecPkg::stateT2:
               if (!readyN)
                  state <= fetchExecPkg::stateTi;
            default:
               state <= fetchExecPkg::stateTi;
         endcase

         // Strobe only during T1
         adsN <= !startCycle;

         if (startCycle)
         begin
            grantData   <= dataRequest.pending;
            address     <= winner.addr[31:2];
            byteEnableN <= enableFor(winner.width, winner.addr[1:0]);
            writeReadN  <= winner.write;
            dataCodeN   <= !winner.code;
            memIoN      <= winner.memory;
         end
      end
   end

   always_ff @(posedge CLOCK)
   begin
      if (startCycle)
         dataOut <= laneData(winner);
   end

   adsSingleCycle: assert property (@(posedge CLOCK) disable iff (RESET)
      !adsN |=> adsN)
      else $error("ADS_n held low for more than one cycle");

   // Misaligned dword stores are not split
   dwordStoreAligned: assert property (@(posedge CLOCK) disable iff (RESET)
      dataRequest.pending && dataRequest.width == fetchExecPkg::widthDword
         |-> dataRequest.addr[1:0] == 2'b00)
      else $error("misaligned dword data request at %h", dataRequest.addr);

endmodule

// ==== source/fetchExecPkg.sv ====
package fetchExecPkg;

   typedef logic [31:0] byteAddr_t;
   typedef logic [29:0] dwordAddr_t;
   typedef logic [31:0] dataWord_t;
   typedef logic [3:0]  byteEnable_t;
   typedef logic [3:0]  queuePtr_t;
   typedef logic [4:0]  queueCount_t;
   typedef logic [7:0]  opcodeByte_t;

   localparam byteAddr_t resetVector = 32'h000F_FFF0;
   localparam int queueDepth = 16;
   localparam int fetchBytes = 4;
   // Longest instruction is opcode plus a dword immediate
   localparam int windowBytes = 5;

   localparam opcodeByte_t opNop       = 8'h90;
   localparam opcodeByte_t opIncEax    = 8'h40;
   localparam opcodeByte_t opIncEbx    = 8'h43;
   localparam opcodeByte_t opMovEaxImm = 8'hB8;
   localparam opcodeByte_t opMovEbxImm = 8'hBB;
   localparam opcodeByte_t opJmpShort  = 8'hEB;
   localparam opcodeByte_t opOutAl     = 8'hE6;
   localparam opcodeByte_t opMovStore  = 8'h89;
   localparam opcodeByte_t opHlt       = 8'hF4;

   typedef enum logic {
      widthByte,
      widthDword
   } accessWidth_t;

   typedef enum logic [1:0] {
      stateTi,
      stateT1,
      stateT2,
      stateTh
   } busState_t;

   typedef enum logic [1:0] {
      execDecode,
      execWaitBus,
      execHalt
   } execState_t;

   typedef struct packed {
      logic         pending;
      logic         write;
      logic         memory;
      logic         code;
      accessWidth_t width;
      byteAddr_t    addr;
      dataWord_t    data;
   } busRequest_t;

   // Entry 0 is the oldest byte in the queue
   typedef struct packed {
      queueCount_t                       count;
      opcodeByte_t [windowBytes - 1:0]   bytes;
   } fetchWindow_t;

endpackage

// ==== source/fetchExecTop.sv ====
`timescale 1ns/1ps

module fetchExecTop (
   input  logic                      CLOCK,
   input  logic                      RESET,
   input  fetchExecPkg::dataWord_t   dataIn,
   input  logic                      readyN,
   input  logic                      hold,
   output fetchExecPkg::dwordAddr_t  address,
   output fetchExecPkg::byteEnable_t byteEnableN,
   output logic                      writeReadN,
   output logic                      dataCodeN,
   output logic                      memIoN,
   output logic                      adsN,
   output fetchExecPkg::dataWord_t   dataOut
);

   fetchExecPkg::busRequest_t  codeRequest;
   fetchExecPkg::busRequest_t  dataRequest;
   fetchExecPkg::dataWord_t    readData;
   fetchExecPkg::fetchWindow_t window;
   fetchExecPkg::byteAddr_t    flushTarget;
   logic                       codeDone;
   logic                       dataDone;
   logic                       flush;
   logic [2:0]                 consume;

   busCycleFsm bus0 (
      .CLOCK       (CLOCK),
      .RESET       (RESET),
      .readyN      (readyN),
      .hold        (hold),
      .dataIn      (dataIn),
      .codeRequest (codeRequest),
      .dataRequest (dataRequest),
      .codeDone    (codeDone),
      .dataDone    (dataDone),
      .readData    (readData),
      .address     (address),
      .byteEnableN (byteEnableN),
      .writeReadN  (writeReadN),
      .dataCodeN   (dataCodeN),
      .memIoN      (memIoN),
      .adsN        (adsN),
      .dataOut     (dataOut)
   );

   prefetchQueue queue0 (
      .CLOCK       (CLOCK),
      .RESET       (RESET),
      .codeDone    (codeDone),
      .readData    (readData),
      .consume     (consume),
      .flush       (flush),
      .flushTarget (flushTarget),
      .codeRequest (codeRequest),
      .window      (window)
   );

   instructionDecoder decoder0 (
      .CLOCK       (CLOCK),
      .RESET       (RESET),
      .window      (window),
      .dataDone    (dataDone),
      .dataRequest (dataRequest),
      .consume     (consume),
      .flush       (flush),
      .flushTarget (flushTarget)
   );

endmodule

// ==== source/instructionDecoder.sv ====
`timescale 1ns/1ps

module instructionDecoder (
   input  logic                       CLOCK,
   input  logic                       RESET,
   input  fetchExecPkg::fetchWindow_t window,
   input  logic                       dataDone,
   output fetchExecPkg::busRequest_t  dataRequest,
   output logic [2:0]                 consume,
   output logic                       flush,
   output fetchExecPkg::byteAddr_t    flushTarget
);

   fetchExecPkg::execState_t   state;
   fetchExecPkg::dataWord_t    eax;
   fetchExecPkg::dataWord_t    ebx;
   fetchExecPkg::byteAddr_t    ip;
   fetchExecPkg::opcodeByte_t  opcode;
   fetchExecPkg::queueCount_t  needed;
   fetchExecPkg::dataWord_t    immediate;
   logic                       present;
   logic                       requestPending;
   logic                       requestMemory;
   fetchExecPkg::accessWidth_t requestWidth;
   fetchExecPkg::byteAddr_t    requestAddr;
   fetchExecPkg::dataWord_t    requestData;

   assign opcode    = window.bytes[0];
   assign immediate = {window.bytes[4], window.bytes[3], window.bytes[2], window.bytes[1]};

   // Bytes each instruction needs in the queue
   always_comb
   begin
      case (opcode)
         fetchExecPkg::opMovEaxImm,
         fetchExecPkg::opMovEbxImm:
            needed = 5'd5;
         fetchExecPkg::opJmpShort,
         fetchExecPkg::opOutAl,
         fetchExecPkg::opMovStore:
            needed = 5'd2;
         default:
            needed = 5'd1;
      endcase
   end

   assign present = (state == fetchExecPkg::execDecode) && (window.count >= needed);

   assign flush       = present && (opcode == fetchExecPkg::opJmpShort);
   assign flushTarget = ip + 32'd2 + {{24{window.bytes[1][7]}}, window.bytes[1]};

   // Bus instructions keep their bytes until the write is done
   always_comb
   begin
      if (state == fetchExecPkg::execWaitBus)
      begin
         consume = dataDone ? 3'd2 : 3'd0;
      end
      else if (!present)
      begin
         consume = 3'd0;
      end
      else
      begin
         case (opcode)
            fetchExecPkg::opJmpShort,
            fetchExecPkg::opOutAl,
            fetchExecPkg::opMovStore:
               consume = 3'd0;
            fetchExecPkg::opMovEaxImm,
            fetchExecPkg::opMovEbxImm:
               consume = 3'd5;
            default:
               consume = 3'd1;
         endcase
      end
   end

   always_comb
   begin
      dataRequest         = '0;
      dataRequest.pending = requestPending;
      dataRequest.write   = 1'b1;
      dataRequest.memory  = requestMemory;
      dataRequest.width   = requestWidth;
      dataRequest.addr    = requestAddr;
      dataRequest.data    = requestData;
   end

   always_ff @(posedge CLOCK or posedge RESET)
   begin
      if (RESET)
      begin
         state          <= fetchExecPkg::execDecode;
         eax            <= '0;
         ebx            <= '0;
         ip             <= fetchExecPkg::resetVector;
         requestPending <= 1'b0;
      end
      else
      begin
         // Pointer follows the bytes taken from the queue
         if (flush)
            ip <= flushTarget;
         else
            ip <= ip + fetchExecPkg::byteAddr_t'(consume);

         case (state)
            fetchExecPkg::execDecode:
               if (present)
               begin
                  case (opcode)
                     fetchExecPkg::opIncEax:    eax <= eax + 32'd1;
                     fetchExecPkg::opIncEbx:    ebx <= ebx + 32'd1;
                     fetchExecPkg::opMovEaxImm: eax <= immediate;
                     fetchExecPkg::opMovEbxImm: ebx <= immediate;
                     fetchExecPkg::opOutAl,
                     fetchExecPkg::opMovStore:
                     begin
                        requestPending <= 1'b1;
                        state          <= fetchExecPkg::execWaitBus;
                     end
                     fetchExecPkg::opHlt:       state <= fetchExecPkg::execHalt;
                     default:                   ;
                  endcase
               end
            fetchExecPkg::execWaitBus:
               if (dataDone)
               begin
                  requestPending <= 1'b0;
                  state          <= fetchExecPkg::execDecode;
               end
            default:
               ;
         endcase
      end
   end

   // Request fields, stable while pending
   always_ff @(posedge CLOCK)
   begin
      if (present && opcode == fetchExecPkg::opOutAl)
      begin
         requestMemory <= 1'b0;
         requestWidth  <= fetchExecPkg::widthByte;
         requestAddr   <= {24'd0, window.bytes[1]};
         requestData   <= eax;
      end
      else if (present && opcode == fetchExecPkg::opMovStore)
      begin
         requestMemory <= 1'b1;
         requestWidth  <= fetchExecPkg::widthDword;
         requestAddr   <= ebx;
         requestData   <= eax;
      end
   end

endmodule

// ==== source/prefetchQueue.sv ====
`timescale 1ns/1ps

module prefetchQueue (
   input  logic                       CLOCK,
   input  logic                       RESET,
   input  logic                       codeDone,
   input  fetchExecPkg::dataWord_t    readData,
   input  logic [2:0]                 consume,
   input  logic                       flush,
   input  fetchExecPkg::byteAddr_t    flushTarget,
   output fetchExecPkg::busRequest_t  codeRequest,
   output fetchExecPkg::fetchWindow_t window
);

   fetchExecPkg::opcodeByte_t ring [fetchExecPkg::queueDepth];
   fetchExecPkg::queuePtr_t   readPtr;
   fetchExecPkg::queuePtr_t   writePtr;
   fetchExecPkg::queueCount_t count;
   fetchExecPkg::queueCount_t written;
   fetchExecPkg::byteAddr_t   fetchPtr;
   fetchExecPkg::byteAddr_t   requestAddr;
   logic                      requestPending;
   logic                      discard;
   logic [1:0]                skip;
   logic                      writeEnable;
   logic                      issue;

   // Data of a fetch overtaken by a flush is dropped
   assign writeEnable = codeDone && !discard && !flush;
   assign written = writeEnable ?
                    fetchExecPkg::queueCount_t'(fetchExecPkg::fetchBytes - skip) : '0;
   assign issue = !requestPending && !flush &&
                  count <= fetchExecPkg::queueCount_t'(fetchExecPkg::queueDepth -
                                                      fetchExecPkg::fetchBytes);

   always_comb
   begin
      codeRequest         = '0;
      codeRequest.pending = requestPending;
      codeRequest.memory  = 1'b1;
      codeRequest.code    = 1'b1;
      codeRequest.width   = fetchExecPkg::widthDword;
      codeRequest.addr    = requestAddr;
   end

   always_comb
   begin
      window.count = count;
      for (int i = 0; i < fetchExecPkg::windowBytes; i++)
         window.bytes[i] = ring[readPtr + fetchExecPkg::queuePtr_t'(i)];
   end

   // Little-endian, leading bytes skipped after a jump
   always_ff @(posedge CLOCK)
   begin
      if (writeEnable)
      begin
         for (int i = 0; i < fetchExecPkg::fetchBytes; i++)
            if (i >= skip)
               ring[writePtr + fetchExecPkg::queuePtr_t'(i - skip)] <= readData[8 * i +: 8];
      end
   end

   always_ff @(posedge CLOCK or posedge RESET)
   begin
      if (RESET)
      begin
         readPtr        <= '0;
         writePtr       <= '0;
         count          <= '0;
         fetchPtr       <= fetchExecPkg::resetVector;
         requestAddr    <= fetchExecPkg::resetVector;
         requestPending <= 1'b0;
         discard        <= 1'b0;
         skip           <= '0;
      end
      else
      begin
         if (flush)
         begin
            readPtr  <= '0;
            writePtr <= '0;
            count    <= '0;
            fetchPtr <= {flushTarget[31:2], 2'b00};
            skip     <= flushTarget[1:0];
            discard  <= requestPending && !codeDone;
         end
         else
         begin
            readPtr  <= readPtr + fetchExecPkg::queuePtr_t'(consume);
            writePtr <= writePtr + fetchExecPkg::queuePtr_t'(written);
            count    <= count + written - fetchExecPkg::queueCount_t'(consume);
            if (writeEnable)
               skip <= '0;
            if (codeDone)
               discard <= 1'b0;
            if (issue)
               fetchPtr <= fetchPtr + fetchExecPkg::byteAddr_t'(fetchExecPkg::fetchBytes);
         end

         if (codeDone)
         begin
            requestPending <= 1'b0;
         end
         else if (issue)
         begin
            requestPending <= 1'b1;
            requestAddr    <= fetchPtr;
         end
      end
   end

   queueRoom: assert property (@(posedge CLOCK) disable iff (RESET)
      writeEnable |-> count <= fetchExecPkg::queueCount_t'(fetchExecPkg::queueDepth -
                                                         fetchExecPkg::fetchBytes))
      else $error("code fetch written with %0d bytes queued", count);

   consumeBounded: assert property (@(posedge CLOCK) disable iff (RESET)
      consume <= count)
      else $error("consume %0d exceeds queue count %0d", consume, count);

endmodule

// ==== tests/fetchExecModel.svh ====
`ifndef FETCH_EXEC_MODEL_SVH
`define FETCH_EXEC_MODEL_SVH

typedef struct packed {
   fetchExecPkg::dwordAddr_t  address;
   fetchExecPkg::byteEnable_t byteEnableN;
   fetchExecPkg::dataWord_t   data;
   logic                      memIoN;
} busWrite_t;

localparam int programLength = 44;

// Code at the reset vector, jump targets at offsets 25, 17 and 37
fetchExecPkg::opcodeByte_t programImage [programLength] = '{
   8'hB8, 8'h44, 8'h33, 8'h22, 8'h11,
   8'hE6, 8'h10,
   8'h40,
   8'hBB, 8'h00, 8'h20, 8'h00, 8'h00,
   8'h89, 8'h03,
   8'hEB, 8'h08,
   8'h40,
   8'hE6, 8'h22,
   8'hEB, 8'h0F,
   8'hCC, 8'hCC, 8'hCC,
   8'hD6,
   8'h43, 8'h43, 8'h43, 8'h43,
   8'hE6, 8'h31,
   8'hEB, 8'hEF,
   8'hCC, 8'hCC, 8'hCC,
   8'h89, 8'h03,
   8'h90,
   8'hF4,
   8'hF4, 8'hF4, 8'hF4
};

busWrite_t                expectedWrites [$];
fetchExecPkg::dwordAddr_t expectedTargets [$];

// Outside the image every byte mixes all four address bytes
function automatic fetchExecPkg::opcodeByte_t codeByte(input fetchExecPkg::byteAddr_t addr);
   fetchExecPkg::byteAddr_t offset;
   offset = addr - fetchExecPkg::resetVector;
   if (offset < programLength)
      return programImage[offset];
   return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ addr[31:24];
endfunction

function automatic fetchExecPkg::dataWord_t codeDword(input fetchExecPkg::dwordAddr_t addr);
   fetchExecPkg::byteAddr_t base;
   base = {addr, 2'b00};
   return {codeByte(base + 32'd3), codeByte(base + 32'd2),
           codeByte(base + 32'd1), codeByte(base)};
endfunction

// Runs the program and lists the bus writes and jump fetch addresses
function automatic void predictWrites();
   fetchExecPkg::byteAddr_t   ip;
   fetchExecPkg::dataWord_t   eax;
   fetchExecPkg::dataWord_t   ebx;
   fetchExecPkg::dataWord_t   immediate;
   fetchExecPkg::opcodeByte_t opcode;
   fetchExecPkg::opcodeByte_t operand;
   busWrite_t                 nextWrite;
   logic                      halted;
   int                        steps;
   ip     = fetchExecPkg::resetVector;
   eax    = '0;
   ebx    = '0;
   halted = 1'b0;
   steps  = 0;
   while (!halted && steps < 1000)
   begin
      opcode    = codeByte(ip);
      operand   = codeByte(ip + 32'd1);
      immediate = {codeByte(ip + 32'd4), codeByte(ip + 32'd3), codeByte(ip + 32'd2), operand};
      steps++;
      case (opcode)
         fetchExecPkg::opIncEax:
         begin
            eax = eax + 32'd1;
            ip  = ip + 32'd1;
         end
         fetchExecPkg::opIncEbx:
         begin
            ebx = ebx + 32'd1;
            ip  = ip + 32'd1;
         end
         fetchExecPkg::opMovEaxImm:
         begin
            eax = immediate;
            ip  = ip + 32'd5;
         end
         fetchExecPkg::opMovEbxImm:
         begin
            ebx = immediate;
            ip  = ip + 32'd5;
         end
         fetchExecPkg::opJmpShort:
         begin
            ip = ip + 32'd2 + {{24{operand[7]}}, operand};
            expectedTargets.push_back(ip[31:2]);
         end
         fetchExecPkg::opOutAl:
         begin
            // AL goes to the lane of the port number
            nextWrite.address                      = {24'd0, operand[7:2]};
            nextWrite.byteEnableN                  = 4'b1111;
            nextWrite.byteEnableN[operand[1:0]]    = 1'b0;
            nextWrite.data                         = {24'd0, eax[7:0]} << (8 * operand[1:0]);
            nextWrite.memIoN                       = 1'b0;
            expectedWrites.push_back(nextWrite);
            ip = ip + 32'd2;
         end
         fetchExecPkg::opMovStore:
         begin
            nextWrite.address     = ebx[31:2];
            nextWrite.byteEnableN = 4'b0000;
            nextWrite.data        = eax;
            nextWrite.memIoN      = 1'b1;
            expectedWrites.push_back(nextWrite);
            ip = ip + 32'd2;
         end
         fetchExecPkg::opHlt:
            halted = 1'b1;
         default:
            ip = ip + 32'd1;
      endcase
   end
endfunction

`endif

// ==== tests/fetchExecTb.sv ====
`timescale 1ns/1ps

module fetchExecTb;

   `include "fetchExecModel.svh"

   logic                      CLOCK;
   logic                      RESET;
   fetchExecPkg::dataWord_t   dataIn;
   logic                      readyN;
   logic                      hold;
   fetchExecPkg::dwordAddr_t  address;
   fetchExecPkg::byteEnable_t byteEnableN;
   logic                      writeReadN;
   logic                      dataCodeN;
   logic                      memIoN;
   logic                      adsN;
   fetchExecPkg::dataWord_t   dataOut;

   int                        errorCount = 0;
   int                        checkCount = 0;
   int                        busCycles = 0;
   int                        writesCompared = 0;
   logic [15:0]               waitLfsr = 16'd47;
   logic [15:0]               holdLfsr = 16'd47;
   logic                      holdLast = 1'b0;
   busWrite_t                 writeLog [$];
   fetchExecPkg::dwordAddr_t  codeFetchLog [$];
   event                      writeLogged;

   fetchExecTop dut0 (
      .CLOCK       (CLOCK),
      .RESET       (RESET),
      .dataIn      (dataIn),
      .readyN      (readyN),
      .hold        (hold),
      .address     (address),
      .byteEnableN (byteEnableN),
      .writeReadN  (writeReadN),
      .dataCodeN   (dataCodeN),
      .memIoN      (memIoN),
      .adsN        (adsN),
      .dataOut     (dataOut)
   );

   initial
   begin
      CLOCK = 1'b0;
      forever
         #10 CLOCK = ~CLOCK;
   end

   function automatic logic [15:0] lfsrStep(input logic [15:0] state);
      if (state[0])
         return (state >> 1) ^ 16'hB400;
      return state >> 1;
   endfunction

   task automatic takeBits(inout logic [15:0] state, input int count, output int value);
      value = 0;
      for (int i = 0; i < count; i++)
      begin
         value = (value << 1) | state[0];
         state = lfsrStep(state);
      end
   endtask

   task automatic checkValue(input string testName, input logic [63:0] expected,
                             input logic [63:0] actual);
      checkCount++;
      if (expected !== actual)
      begin
         errorCount++;
         $display("FAIL %s: expected %h, actual %h", testName, expected, actual);
      end
   endtask

   // Only enabled lanes carry defined data
   function automatic fetchExecPkg::dataWord_t laneMask(input fetchExecPkg::byteEnable_t enablesN);
      fetchExecPkg::dataWord_t mask;
      for (int lane = 0; lane < 4; lane++)
         mask[8 * lane +: 8] = enablesN[lane] ? 8'h00 : 8'hFF;
      return mask;
   endfunction

   // Memory and I/O responder, one bus cycle per ADS_n
   always
   begin : respondToBus
      busWrite_t                loggedWrite;
      fetchExecPkg::dwordAddr_t cycleAddress;
      logic                     cycleIsWrite;
      int                       waitCycles;
      @(posedge CLOCK);
      if (!RESET && !adsN)
      begin
         cycleAddress = address;
         cycleIsWrite = writeReadN;
         if (busCycles == 0)
         begin
            checkValue("first cycle address", fetchExecPkg::resetVector >> 2, address);
            checkValue("first cycle byte enables", 4'b0000, byteEnableN);
            checkValue("first cycle type", 3'b001, {writeReadN, dataCodeN, memIoN});
         end
         busCycles++;
         if (cycleIsWrite)
         begin
            loggedWrite.address     = address;
            loggedWrite.byteEnableN = byteEnableN;
            loggedWrite.data        = dataOut;
            loggedWrite.memIoN      = memIoN;
            writeLog.push_back(loggedWrite);
            -> writeLogged;
         end
         else
         begin
            codeFetchLog.push_back(address);
         end
         takeBits(waitLfsr, 2, waitCycles);
         for (int i = 0; i < waitCycles; i++)
            @(posedge CLOCK);
         #2;
         if (!cycleIsWrite)
            dataIn = codeDword(cycleAddress);
         readyN = 1'b0;
         @(posedge CLOCK);
         #2;
         readyN = 1'b1;
      end
   end

   always @(posedge CLOCK)
   begin
      if (!RESET && holdLast && !adsN)
      begin
         errorCount++;
         $display("ERROR: ADS_n fell while HOLD was high");
      end
      holdLast = hold;
   end

   // A few hold windows at random idle points
   initial
   begin : driveHold
      int gap;
      int length;
      int tries;
      for (int n = 0; n < 4; n++)
      begin
         takeBits(holdLfsr, 4, gap);
         for (int i = 0; i < gap + 8; i++)
            @(posedge CLOCK);
         tries = 0;
         @(posedge CLOCK);
         while (!adsN && tries < 20)
         begin
            @(posedge CLOCK);
            tries++;
         end
         #2;
         hold = 1'b1;
         takeBits(holdLfsr, 2, length);
         for (int i = 0; i < length + 2; i++)
            @(posedge CLOCK);
         #2;
         hold = 1'b0;
      end
   end

   initial
   begin : compareWrites
      busWrite_t expectedWrite;
      busWrite_t actualWrite;
      forever
      begin
         @(writeLogged);
         actualWrite = writeLog[writesCompared];
         if (writesCompared >= expectedWrites.size())
         begin
            errorCount++;
            $display("ERROR: unexpected write to %h after the last predicted write",
                     actualWrite.address);
         end
         else
         begin
            expectedWrite = expectedWrites[writesCompared];
            checkValue($sformatf("write %0d address", writesCompared),
                       expectedWrite.address, actualWrite.address);
            checkValue($sformatf("write %0d byte enables", writesCompared),
                       expectedWrite.byteEnableN, actualWrite.byteEnableN);
            checkValue($sformatf("write %0d data", writesCompared),
                       expectedWrite.data & laneMask(expectedWrite.byteEnableN),
                       actualWrite.data & laneMask(expectedWrite.byteEnableN));
            checkValue($sformatf("write %0d memIoN", writesCompared),
                       expectedWrite.memIoN, actualWrite.memIoN);
         end
         writesCompared++;
      end
   end

   initial
   begin : runTest
      int   waited;
      int   targetIndex;
      int   jumpFetches;
      logic found;
      RESET  = 1'b1;
      readyN = 1'b1;
      hold   = 1'b0;
      dataIn = '0;
      predictWrites();
      for (int i = 0; i < 4; i++)
      begin
         @(posedge CLOCK);
         checkValue("adsN during reset", 1'b1, adsN);
      end
      #2;
      RESET = 1'b0;
      @(posedge CLOCK);
      checkValue("adsN after reset", 1'b1, adsN);

      waited = 0;
      while (writeLog.size() < expectedWrites.size() && waited < 5000)
      begin
         @(posedge CLOCK);
         waited++;
      end
      if (writeLog.size() < expectedWrites.size())
      begin
         errorCount++;
         $display("ERROR: timeout after %0d cycles with %0d of %0d writes seen",
                  waited, writeLog.size(), expectedWrites.size());
      end

      // Quiet window after the last write before HLT
      for (int i = 0; i < 200; i++)
         @(posedge CLOCK);
      checkValue("write count", expectedWrites.size(), writeLog.size());

      // Every break in the sequential fetch lands on a jump target, in order
      targetIndex = 0;
      jumpFetches = 0;
      for (int j = 1; j < codeFetchLog.size(); j++)
      begin
         if (codeFetchLog[j] != codeFetchLog[j - 1] + 30'd1)
         begin
            found = 1'b0;
            checkCount++;
            jumpFetches++;
            while (targetIndex < expectedTargets.size() && !found)
            begin
               if (expectedTargets[targetIndex] == codeFetchLog[j])
                  found = 1'b1;
               targetIndex++;
            end
            if (!found)
            begin
               errorCount++;
               $display("ERROR: code fetch at %h is neither sequential nor a jump target",
                        codeFetchLog[j]);
            end
         end
      end
      checkCount++;
      if (jumpFetches == 0)
      begin
         errorCount++;
         $display("ERROR: no code fetch restarted at a jump target");
      end

      $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule
